// ==== rtl/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Sizes shared by the fetch buffer and the instruction cache

// Words per cache line
`define LINE_WORDS 4

// Instruction ROM depth in words, a power of two so indices wrap
`define ROM_WORDS 128

// Lines the fetch buffer may hold plus have in flight
`define FB_SLOTS 2

// Default cache latency in cycles
`define IC_LATENCY 2

`endif

// ==== rtl/memPkg.sv ====
`include "fetch_macros.svh"

// Types seen on the memory side of the fetch path

package memPkg;

    // Byte address on the request bus
    typedef logic [31:0] addrT;

    // One ROM word
    typedef logic [31:0] wordT;

    // A whole cache line, word 0 holds the lowest address
    typedef wordT [`LINE_WORDS-1:0] lineT;

    // Request tag, carries the fetch epoch and comes back with the line
    typedef logic [1:0] reqIdT;

    // Word index into the instruction ROM
    typedef logic [$clog2(`ROM_WORDS)-1:0] romIdxT;

endpackage

// ==== rtl/fetchPkg.sv ====
`include "fetch_macros.svh"

// Types seen on the fetch side

package fetchPkg;

    typedef logic [31:0] pcT;     // Byte PC, word aligned
    typedef logic [31:0] instrT;

    // Word position inside a line
    typedef logic [$clog2(`LINE_WORDS)-1:0] wordOffT;

    // Line slot pointer and slot count
    typedef logic [$clog2(`FB_SLOTS)-1:0]   slotIdxT;
    typedef logic [$clog2(`FB_SLOTS+1)-1:0] slotCntT;

    typedef enum logic {
        idle,       // Waiting for the first redirect
        fetching
    } fetchStateT;

endpackage

// ==== rtl/icacheBusIf.sv ====
`timescale 1ns/1ps

// Line request and response strobes between fetch buffer and cache
interface icacheBusIf;
    import memPkg::*;

    // Request side
    logic  reqValid;
    reqIdT reqId;
    addrT  reqAddr;     // Always line aligned

    // Response side, fixed latency, no stall
    logic  rspValid;
    reqIdT rspId;       // Echo of reqId
    lineT  rspData;

    modport requester (
        output reqValid,
        output reqId,
        output reqAddr,
        input  rspValid,
        input  rspId,
        input  rspData
    );

    modport responder (
        input  reqValid,
        input  reqId,
        input  reqAddr,
        output rspValid,
        output rspId,
        output rspData
    );

endinterface

// ==== rtl/icache.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module icache #(
    parameter int LATENCY = `IC_LATENCY
) (
    input  logic            clk,
    input  logic            reset,
    icacheBusIf.responder   bus,
    input  logic            romWrite,
    input  memPkg::romIdxT  romAddr,
    input  memPkg::wordT    romData
);
    import memPkg::*;

    wordT   rom [`ROM_WORDS];
    romIdxT baseIdx;
    lineT   readLine;

    // Response pipeline, stage 0 is loaded straight from the ROM
    logic   pipeValid [LATENCY];
    reqIdT  pipeId    [LATENCY];
    lineT   pipeData  [LATENCY];

    // Load port
    always_ff @(posedge clk) begin
        if (romWrite) begin
            rom[romAddr] <= romData;
        end
    end

    assign baseIdx = bus.reqAddr[2 +: $bits(romIdxT)];

    // Whole line lookup, indices wrap at the end of the ROM
    always_comb begin
        for (int w = 0; w < `LINE_WORDS; w++) begin
            readLine[w] = rom[romIdxT'(int'(baseIdx) + w)];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < LATENCY; s++) begin
                pipeValid[s] <= 1'b0;
            end
        end else begin
            pipeValid[0] <= bus.reqValid;
            for (int s = 1; s < LATENCY; s++) begin
                pipeValid[s] <= pipeValid[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        pipeId[0]   <= bus.reqId;
        pipeData[0] <= readLine;
        for (int s = 1; s < LATENCY; s++) begin
            pipeId[s]   <= pipeId[s-1];
            pipeData[s] <= pipeData[s-1];
        end
    end

    assign bus.rspValid = pipeValid[LATENCY-1];
    assign bus.rspId    = pipeId[LATENCY-1];
    assign bus.rspData  = pipeData[LATENCY-1];

    // Every request comes back exactly LATENCY cycles later
    rspTiming: assert property (
        @(posedge clk) disable iff (reset)
        bus.rspValid == $past(bus.reqValid, LATENCY)
    ) else $error("icache response out of step with requests");

endmodule

// ==== rtl/fetchBuffer.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetchBuffer (
    input  logic             clk,
    input  logic             reset,
    icacheBusIf.requester    bus,
    input  logic             redirect,
    input  fetchPkg::pcT     redirectPc,
    output logic             instrValid,
    output fetchPkg::pcT     instrPc,
    output fetchPkg::instrT  instr
);
    import memPkg::*;
    import fetchPkg::*;

    localparam int LINE_BYTES = `LINE_WORDS * 4;

    fetchStateT state;
    reqIdT      epoch;          // Bumped on each redirect
    addrT       nextLine;       // Next line to request
    addrT       rspLine;        // Line expected with the next good response
    slotCntT    outstanding;    // Current-epoch requests in flight
    slotCntT    held;           // Lines sitting in the queue
    slotIdxT    head;
    slotIdxT    tail;
    wordOffT    firstOff;       // Start word for the next accepted line

    // Line queue
    lineT       lineQ   [`FB_SLOTS];
    pcT         basePcQ [`FB_SLOTS];
    wordOffT    offQ    [`FB_SLOTS];  // Next word to emit from each slot

    logic       accept;
    logic       drain;
    logic       pop;
    logic       issue;
    addrT       redirectLine;
    wordOffT    headOff;

    function automatic slotIdxT nextSlot(slotIdxT ptr);
        if (int'(ptr) == `FB_SLOTS - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign redirectLine = addrT'(redirectPc) & ~addrT'(LINE_BYTES - 1);
    assign headOff      = offQ[head];

    // Stale epochs and anything racing a redirect are dropped
    assign accept = bus.rspValid && (bus.rspId == epoch) && !redirect;
    assign drain  = (held != '0) && !redirect;
    assign pop    = drain && (int'(headOff) == `LINE_WORDS - 1);   // Last word of head line

    // One credit per line held or in flight
    assign issue  = (state == fetching) && !redirect &&
                    (int'(held) + int'(outstanding) < `FB_SLOTS);

    // Epoch has already moved when the first request after a redirect leaves
    assign bus.reqId = epoch;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= idle;
            epoch        <= '0;
            outstanding  <= '0;
            held         <= '0;
            head         <= '0;
            tail         <= '0;
            firstOff     <= '0;
            bus.reqValid <= 1'b0;
        end else if (redirect) begin
            state        <= fetching;
            epoch        <= epoch + 1'b1;
            outstanding  <= slotCntT'(1);   // First line goes out right away
            held         <= '0;
            head         <= '0;
            tail         <= '0;
            firstOff     <= wordOffT'(redirectPc >> 2);
            bus.reqValid <= 1'b1;
        end else begin
            bus.reqValid <= issue;
            outstanding  <= outstanding + slotCntT'(issue) - slotCntT'(accept);
            held         <= held + slotCntT'(accept) - slotCntT'(pop);
            if (accept) begin
                tail     <= nextSlot(tail);
                firstOff <= '0;     // Only the first line starts mid-line
            end
            if (pop) begin
                head <= nextSlot(head);
            end
        end
    end

    // Request and response line addresses
    always_ff @(posedge clk) begin
        if (redirect) begin
            bus.reqAddr <= redirectLine;
            nextLine    <= redirectLine + addrT'(LINE_BYTES);
            rspLine     <= redirectLine;
        end else begin
            if (issue) begin
                bus.reqAddr <= nextLine;
                nextLine    <= nextLine + addrT'(LINE_BYTES);
            end
            if (accept) begin
                rspLine <= rspLine + addrT'(LINE_BYTES);
            end
        end
    end

    // Head and tail never meet while both are written
    always_ff @(posedge clk) begin
        if (accept) begin
            lineQ[tail]   <= bus.rspData;
            basePcQ[tail] <= pcT'(rspLine);
            offQ[tail]    <= firstOff;
        end
        if (drain && !pop) begin
            offQ[head] <= headOff + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instrValid <= 1'b0;
        end else begin
            instrValid <= drain;
        end
    end

    always_ff @(posedge clk) begin
        if (drain) begin
            instrPc <= basePcQ[head] + {headOff, 2'b00};
            instr   <= instrT'(lineQ[head][headOff]);
        end
    end

    creditBound: assert property (
        @(posedge clk) disable iff (reset)
        int'(held) + int'(outstanding) <= `FB_SLOTS
    ) else $error("Fetch buffer over its line credits");

    // Nothing comes back or goes out between reset and the first redirect
    quietWhileIdle: assert property (
        @(posedge clk) disable iff (reset)
        (state == idle) |-> !instrValid && !bus.rspValid
    ) else $error("Fetch path active before the first redirect");

endmodule

// ==== rtl/fetchTop.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

// Fetch front end, fetch buffer feeding off the instruction ROM cache
module fetchTop (
    input  logic             clk,
    input  logic             reset,
    input  logic             romWrite,
    input  memPkg::romIdxT   romAddr,
    input  memPkg::wordT     romData,
    input  logic             redirect,
    input  fetchPkg::pcT     redirectPc,
    output logic             instrValid,
    output fetchPkg::pcT     instrPc,
    output fetchPkg::instrT  instr
);

    icacheBusIf icBus ();

    fetchBuffer uFetchBuffer (
        .clk        (clk),
        .reset      (reset),
        .bus        (icBus.requester),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instrValid (instrValid),
        .instrPc    (instrPc),
        .instr      (instr)
    );

    icache #(
        .LATENCY (`IC_LATENCY)
    ) uIcache (
        .clk      (clk),
        .reset    (reset),
        .bus      (icBus.responder),
        .romWrite (romWrite),
        .romAddr  (romAddr),
        .romData  (romData)
    );

endmodule

// ==== testbench/fetchTb.sv ====
`timescale 1ns/1ps

module fetchTb;
    import memPkg::*;
    import fetchPkg::*;

    localparam int MAX_RECS = 256;

    logic   clk;
    logic   reset;
    logic   romWrite;
    romIdxT romAddr;
    wordT   romData;
    logic   redirect;
    pcT     redirectPc;
    logic   instrValid;
    pcT     instrPc;
    instrT  instr;

    // Records from the data file
    byte         recKind [MAX_RECS];
    logic [31:0] recA    [MAX_RECS];
    logic [31:0] recB    [MAX_RECS];
    int          recCount;
    int          watchCycles;

    pcT     expPc    [$];     // Pending expected pairs
    instrT  expInstr [$];
    logic   started;          // Set by the first redirect
    string  testName;
    int     seed;

    fetchTop u_dut (
        .clk        (clk),
        .reset      (reset),
        .romWrite   (romWrite),
        .romAddr    (romAddr),
        .romData    (romData),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instrValid (instrValid),
        .instrPc    (instrPc),
        .instr      (instr)
    );

    always #10 clk = ~clk;

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic readRecords();
        int          fd;
        int          got;
        int          loads;
        int          expects;
        byte         kind;
        string       skipped;
        logic [31:0] a;
        logic [31:0] b;
        loads    = 0;
        expects  = 0;
        recCount = 0;
        fd = $fopen("testbench/fetch_input.txt", "r");
        if (fd == 0) begin
            stopOnError("Could not open testbench/fetch_input.txt");
        end
        got = $fscanf(fd, " %c", kind);
        while (got == 1) begin
            if (kind == "#") begin
                got = $fgets(skipped, fd);    // Comment line
            end else begin
                got = $fscanf(fd, "%h %h", a, b);
                assert (got == 2 && recCount < MAX_RECS) else
                    stopOnError("Data file has a broken record or too many records");
                assert (kind == "L" || kind == "R" || kind == "E") else
                    stopOnError("Data file has a record of unknown kind");
                recKind[recCount] = kind;
                recA[recCount]    = a;
                recB[recCount]    = b;
                recCount++;
                if (kind == "L") loads++;
                if (kind == "E") expects++;
            end
            got = $fscanf(fd, " %c", kind);
        end
        $fclose(fd);
        watchCycles = (loads + expects) * 20 + 200;
    endtask

    // Compare every output beat with the oldest pending pair
    always @(negedge clk) begin
        if (instrValid) begin
            assert (started) else
                stopOnError("instrValid went high before any redirect");
            if (expPc.size() != 0) begin
                assert (instrPc == expPc[0] && instr == expInstr[0]) else
                    stopOnError($sformatf(
                        "Mismatch in %s: expected pc %h instr %h, actual pc %h instr %h",
                        testName, expPc[0], expInstr[0], instrPc, instr));
                void'(expPc.pop_front());
                void'(expInstr.pop_front());
            end
        end
    end

    initial begin
        #1;   // Limit is known once the file is parsed
        repeat (watchCycles) @(posedge clk);
        stopOnError("Run hung, expected instructions did not arrive in time");
    end

    initial begin
        int r;
        int idle;
        int count;
        seed       = 32'h002f_62fc;
        clk        = 1'b0;
        reset      = 1'b1;
        romWrite   = 1'b0;
        romAddr    = '0;
        romData    = '0;
        redirect   = 1'b0;
        redirectPc = '0;
        started    = 1'b0;
        testName   = "quiet after reset";
        readRecords();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (10) @(posedge clk);     // No output expected here
        r = 0;
        while (r < recCount) begin
            idle = $unsigned($random(seed)) % 4;
            repeat (idle) @(posedge clk);
            if (recKind[r] == "L") begin
                while (expPc.size() != 0) @(posedge clk);   // Earlier checks done first
                @(posedge clk);
                romWrite <= 1'b1;
                romAddr  <= romIdxT'(recA[r]);
                romData  <= recB[r];
                @(posedge clk);
                romWrite <= 1'b0;
            end else if (recKind[r] == "R") begin
                @(posedge clk);
                redirect   <= 1'b1;
                redirectPc <= recA[r];
                expPc.delete();     // Old stream is dead from here
                expInstr.delete();
                started  = 1'b1;
                testName = $sformatf("redirect to pc %h", recA[r]);
                count    = recB[r];
                @(posedge clk);
                redirect <= 1'b0;
                for (int k = 1; k <= count; k++) begin
                    assert (r + k < recCount && recKind[r + k] == "E") else
                        stopOnError("Redirect record has fewer expected pairs than it counts");
                    expPc.push_back(recA[r + k]);
                    expInstr.push_back(recB[r + k]);
                end
                r = r + count;
            end else begin
                stopOnError("Expected pair found outside a redirect record");
            end
            r++;
        end
        while (expPc.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== testbench/fetch_input.txt ====
# L romIdx data | R pc count | E pc instr
# All fields are hex
L 0 00000013
L 1 00100093
L 2 00200113
L 3 00308193
L 4 00410213
L 5 00518293
R 0 6
E 0 00000013
E 4 00100093
E 8 00200113
E c 00308193
E 10 00410213
E 14 00518293
L 9 00940493
L a 00a50513
L b 00b58593
R 24 3
E 24 00940493
E 28 00a50513
E 2c 00b58593
L 7e 07e00f13
R 4 2
E 4 00100093
E 8 00200113
R 10 2
E 10 00410213
E 14 00518293
L 7f 07f00f93
R 1f8 4
E 1f8 07e00f13
E 1fc 07f00f93
E 200 00000013
E 204 00100093
L 4 fe010113
L 5 00812e23
R 10 2
E 10 fe010113
E 14 00812e23

// ==== files.f ====
+incdir+rtl
rtl/memPkg.sv
rtl/fetchPkg.sv
rtl/icacheBusIf.sv
rtl/icache.sv
rtl/fetchBuffer.sv
rtl/fetchTop.sv
testbench/fetchTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the fetch front end testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --assert --top-module fetchTb -f files.f -o fetchSim > build.log 2>&1 &&
    ./obj_dir/fetchSim > sim.log 2>&1 ||
    echo "Build or run ended with an error, see build.log and sim.log"
grep -q "Test completed successfully" sim.log 2>/dev/null && echo "PASS" ||
    { echo "FAIL"; exit 1; }
